// ==== source/pic_consts.svh ====
`ifndef PIC_CONSTS_SVH
`define PIC_CONSTS_SVH

// Request lines
`define PIC_LINES 8

// Register addresses
`define PIC_ADDR_MASK 2'd0
`define PIC_ADDR_BASE 2'd1
`define PIC_ADDR_MODE 2'd2
`define PIC_ADDR_CMD  2'd3

// Mode register bits
`define PIC_MODE_LEVEL 0
`define PIC_MODE_AEOI  1
`define PIC_MODE_AROT  2 // Rotate on automatic EOI
`define PIC_MODE_SFNM  3
`define PIC_MODE_SMM   4

// Command codes carried in wr_data[PIC_CMD_MSB:PIC_CMD_LSB]
`define PIC_CMD_MSB 7
`define PIC_CMD_LSB 5
`define PIC_CMD_NONSPEC_EOI     3'd0
`define PIC_CMD_SPEC_EOI        3'd1
`define PIC_CMD_ROT_NONSPEC_EOI 3'd2
`define PIC_CMD_ROT_SPEC_EOI    3'd3
`define PIC_CMD_SET_PRIORITY    3'd4
`define PIC_CMD_NOP             3'd7

`endif

// ==== source/pic_pkg.sv ====
`default_nettype none

`include "pic_consts.svh"

package pic_pkg;

	typedef logic [`PIC_LINES-1:0] pic_lines_t;

	typedef enum logic [1:0] {
		REG_MASK = `PIC_ADDR_MASK,
		REG_BASE = `PIC_ADDR_BASE,
		REG_MODE = `PIC_ADDR_MODE,
		REG_CMD  = `PIC_ADDR_CMD
	} pic_reg_e;

	typedef enum logic [2:0] {
		NONSPEC_EOI     = `PIC_CMD_NONSPEC_EOI,
		SPEC_EOI        = `PIC_CMD_SPEC_EOI,
		ROT_NONSPEC_EOI = `PIC_CMD_ROT_NONSPEC_EOI,
		ROT_SPEC_EOI    = `PIC_CMD_ROT_SPEC_EOI,
		SET_PRIORITY    = `PIC_CMD_SET_PRIORITY,
		NOP             = `PIC_CMD_NOP
	} pic_cmd_e;

	typedef enum logic {
		EDGE  = 1'b0,
		LEVEL = 1'b1
	} pic_trigger_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Rotation helpers around the lowest-priority line rot

	function automatic pic_lines_t rotate_right(input pic_lines_t src, input logic [2:0] rot);
		logic [2*`PIC_LINES-1:0] dbl;
		logic [2:0] amt;
		amt = rot + 3'd1;
		dbl = {src, src} >> amt;
		return dbl[`PIC_LINES-1:0];
	endfunction

	function automatic pic_lines_t rotate_left(input pic_lines_t src, input logic [2:0] rot);
		logic [2*`PIC_LINES-1:0] dbl;
		logic [2:0] amt;
		amt = rot + 3'd1;
		dbl = {src, src} << amt;
		return dbl[2*`PIC_LINES-1:`PIC_LINES];
	endfunction

	// Isolates the lowest set bit and keeps zero as zero
	function automatic pic_lines_t lowest_one(input pic_lines_t src);
		return src & (~src + pic_lines_t'(1));
	endfunction

	function automatic logic [2:0] encode(input pic_lines_t onehot);
		logic [2:0] lvl;
		lvl = 3'd0;
		for (int i = 0; i < `PIC_LINES; i++) begin
			if (onehot[i])
				lvl = 3'(i);
		end
		return lvl;
	endfunction

endpackage

`default_nettype wire

// ==== source/pic_request_latch.sv ====
`default_nettype none

module pic_request_latch import pic_pkg::*; (
	input  wire               clock,
	input  wire               rst_n,
	input  wire pic_lines_t   ir,
	input  wire pic_trigger_e trigger,
	input  wire               ack_pulse,
	input  wire pic_lines_t   ack_level,
	output pic_lines_t        irr
);

	pic_lines_t ir_prev;
	pic_lines_t ir_rise;
	pic_lines_t ack_clear;

	assign ir_rise = ir & ~ir_prev;
	assign ack_clear = ack_pulse ? ack_level : '0;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ir_prev <= '0;
		end else begin
			ir_prev <= ir;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			irr <= '0;
		end else if (trigger == LEVEL) begin
			irr <= ir; // Line state only
		end else begin
			// A fresh edge wins over the clear of the same bit
			irr <= (irr & ~ack_clear) | ir_rise;
		end
	end

endmodule

`default_nettype wire

// ==== source/pic_priority_resolver.sv ====
`default_nettype none

`include "pic_consts.svh"

module pic_priority_resolver import pic_pkg::*; (
	input  wire [2:0]       priority_rotate,
	input  wire pic_lines_t interrupt_mask,
	input  wire pic_lines_t interrupt_special_mask,
	input  wire             special_fully_nest_config,
	input  wire pic_lines_t highest_level_in_service,
	input  wire pic_lines_t interrupt_request_register,
	input  wire pic_lines_t in_service_register,
	output pic_lines_t      interrupt
);

	pic_lines_t masked_request;
	pic_lines_t masked_in_service;
	pic_lines_t rotated_request;
	pic_lines_t rotated_highest;
	pic_lines_t rotated_in_service;
	pic_lines_t ceiling;
	pic_lines_t rotated_interrupt;

	assign masked_request = interrupt_request_register & ~interrupt_mask;
	assign masked_in_service = in_service_register & ~interrupt_special_mask;

	// Highest-priority line moved to bit 0
	assign rotated_request = rotate_right(masked_request, priority_rotate);
	assign rotated_highest = rotate_right(highest_level_in_service, priority_rotate);

	always_comb begin
		rotated_in_service = rotate_right(masked_in_service, priority_rotate);
		// In SFNM the level in service blocks only what lies below it
		if (special_fully_nest_config) begin
			rotated_in_service = (rotated_in_service & ~rotated_highest)
				| {rotated_highest[`PIC_LINES-2:0], 1'b0};
		end
	end

	// Bits strictly above the top in-service bit or all ones when idle
	assign ceiling = lowest_one(rotated_in_service) - pic_lines_t'(1);

	assign rotated_interrupt = lowest_one(rotated_request) & ceiling;

	assign interrupt = rotate_left(rotated_interrupt, priority_rotate);

endmodule

`default_nettype wire

// ==== source/pic_in_service.sv ====
`default_nettype none

module pic_in_service import pic_pkg::*; (
	input  wire             clock,
	input  wire             rst_n,
	input  wire             ack_pulse,
	input  wire pic_lines_t ack_level,
	input  wire             auto_eoi,
	input  wire             eoi_strobe,
	input  wire pic_cmd_e   eoi_cmd,
	input  wire [2:0]       eoi_level,
	input  wire [2:0]       priority_rotate,
	output pic_lines_t      isr,
	output pic_lines_t      highest_in_service,
	output logic            rotate_strobe,
	output logic [2:0]      rotate_level
);

	pic_lines_t eoi_clear;
	pic_lines_t isr_set;

	// Top in-service level under the current rotation
	assign highest_in_service = rotate_left(lowest_one(rotate_right(isr, priority_rotate)),
		priority_rotate);

	always_comb begin
		eoi_clear = '0;
		rotate_strobe = 1'b0;
		rotate_level = eoi_level;
		if (eoi_strobe) begin
			case (eoi_cmd)
				NONSPEC_EOI: eoi_clear = highest_in_service;
				SPEC_EOI: eoi_clear = pic_lines_t'(1) << eoi_level;
				ROT_NONSPEC_EOI: begin
					eoi_clear = highest_in_service;
					rotate_strobe = |highest_in_service; // Idle ISR leaves rotation alone
					rotate_level = encode(highest_in_service);
				end
				ROT_SPEC_EOI: begin
					eoi_clear = pic_lines_t'(1) << eoi_level;
					rotate_strobe = 1'b1;
				end
				default: ;
			endcase
		end
	end

	// AEOI never marks the level in service
	assign isr_set = (ack_pulse && !auto_eoi) ? ack_level : '0;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			isr <= '0;
		end else begin
			isr <= (isr & ~eoi_clear) | isr_set;
		end
	end

endmodule

`default_nettype wire

// ==== source/pic_control.sv ====
`default_nettype none

`include "pic_consts.svh"

module pic_control import pic_pkg::*; (
	input  wire             clock,
	input  wire             rst_n,
	input  wire             wr_en,
	input  wire pic_reg_e   wr_addr,
	input  wire [7:0]       wr_data,
	input  wire             inta,
	input  wire pic_lines_t interrupt,
	input  wire             rotate_strobe,
	input  wire [2:0]       rotate_level,
	output pic_lines_t      mask,
	output pic_lines_t      special_mask,
	output pic_trigger_e    trigger,
	output logic            sfnm,
	output logic            auto_eoi,
	output logic [2:0]      priority_rotate,
	output logic            ack_pulse,
	output pic_lines_t      ack_level,
	output logic            eoi_strobe,
	output pic_cmd_e        eoi_cmd,
	output logic [2:0]      eoi_level,
	output logic            int_out,
	output logic            vector_valid,
	output logic [7:0]      vector
);

	logic [4:0] base;
	logic [`PIC_MODE_SMM:0] mode;
	pic_cmd_e wr_cmd;
	logic cmd_wr;
	logic is_eoi;
	logic [2:0] ack_index;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Programming registers

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mask <= '1;
			base <= '0;
			mode <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				REG_MASK: mask <= wr_data;
				REG_BASE: base <= wr_data[7:3];
				REG_MODE: mode <= wr_data[`PIC_MODE_SMM:0];
				default: ;
			endcase
		end
	end

	assign trigger = mode[`PIC_MODE_LEVEL] ? LEVEL : EDGE;
	assign auto_eoi = mode[`PIC_MODE_AEOI];
	assign sfnm = mode[`PIC_MODE_SFNM];
	assign special_mask = mode[`PIC_MODE_SMM] ? mask : '0; // SMM lifts in-service blocking

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command decode

	assign cmd_wr = wr_en && (wr_addr == REG_CMD);
	assign wr_cmd = pic_cmd_e'(wr_data[`PIC_CMD_MSB:`PIC_CMD_LSB]);

	always_comb begin
		case (wr_cmd)
			NONSPEC_EOI, SPEC_EOI, ROT_NONSPEC_EOI, ROT_SPEC_EOI: is_eoi = 1'b1;
			default: is_eoi = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			eoi_strobe <= 1'b0;
			eoi_cmd <= NOP;
			eoi_level <= 3'd0;
		end else begin
			eoi_strobe <= cmd_wr && is_eoi;
			if (cmd_wr) begin
				eoi_cmd <= wr_cmd;
				eoi_level <= wr_data[2:0];
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			priority_rotate <= 3'd7; // Line 0 highest
		end else if (cmd_wr && wr_cmd == SET_PRIORITY) begin
			priority_rotate <= wr_data[2:0];
		end else if (rotate_strobe) begin
			priority_rotate <= rotate_level;
		end else if (ack_pulse && auto_eoi && mode[`PIC_MODE_AROT]) begin
			priority_rotate <= ack_index;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Acknowledge and vector

	assign ack_pulse = inta && (interrupt != '0);
	assign ack_level = ack_pulse ? interrupt : '0;
	assign ack_index = encode(interrupt);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			int_out <= 1'b0;
			vector_valid <= 1'b0;
		end else begin
			int_out <= |interrupt;
			vector_valid <= inta;
		end
	end

	// Spurious acknowledge reports level 7
	always_ff @(posedge clock) begin
		if (inta)
			vector <= {base, ack_pulse ? ack_index : 3'd7};
	end

endmodule

`default_nettype wire

// ==== source/pic_top.sv ====
`default_nettype none

module pic_top import pic_pkg::*; (
	input  wire             clock,
	input  wire             rst_n,
	input  wire pic_lines_t ir,
	input  wire             wr_en,
	input  wire [1:0]       wr_addr,
	input  wire [7:0]       wr_data,
	input  wire             inta,
	output wire             int_out,
	output wire             vector_valid,
	output wire [7:0]       vector
);

	wire pic_lines_t mask;
	wire pic_lines_t special_mask;
	wire pic_trigger_e trigger;
	wire sfnm;
	wire auto_eoi;
	wire [2:0] priority_rotate;
	wire ack_pulse;
	wire pic_lines_t ack_level;
	wire eoi_strobe;
	wire pic_cmd_e eoi_cmd;
	wire [2:0] eoi_level;
	wire pic_lines_t irr;
	wire pic_lines_t isr;
	wire pic_lines_t highest_in_service;
	wire pic_lines_t interrupt;
	wire rotate_strobe;
	wire [2:0] rotate_level;

	pic_control control_i (
		.clock, .rst_n, .wr_en,
		.wr_addr(pic_reg_e'(wr_addr)),
		.wr_data, .inta, .interrupt, .rotate_strobe, .rotate_level,
		.mask, .special_mask, .trigger, .sfnm, .auto_eoi, .priority_rotate,
		.ack_pulse, .ack_level, .eoi_strobe, .eoi_cmd, .eoi_level,
		.int_out, .vector_valid, .vector
	);

	pic_request_latch request_latch_i (
		.clock, .rst_n, .ir, .trigger, .ack_pulse, .ack_level, .irr
	);

	pic_priority_resolver priority_resolver_i (
		.priority_rotate,
		.interrupt_mask(mask),
		.interrupt_special_mask(special_mask),
		.special_fully_nest_config(sfnm),
		.highest_level_in_service(highest_in_service),
		.interrupt_request_register(irr),
		.in_service_register(isr),
		.interrupt
	);

	pic_in_service in_service_i (
		.clock, .rst_n, .ack_pulse, .ack_level, .auto_eoi,
		.eoi_strobe, .eoi_cmd, .eoi_level, .priority_rotate,
		.isr, .highest_in_service, .rotate_strobe, .rotate_level
	);

endmodule

`default_nettype wire

// ==== bench/pic_assertions.sv ====
`default_nettype none

`include "pic_consts.svh"

module pic_assertions (
	input wire       clock,
	input wire       rst_n,
	input wire       wr_en,
	input wire [1:0] wr_addr,
	input wire [7:0] wr_data,
	input wire       inta,
	input wire       int_out,
	input wire       vector_valid,
	input wire [7:0] vector
);

	logic [4:0] last_base;

	// Shadow of the base register
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			last_base <= '0;
		end else if (wr_en && wr_addr == `PIC_ADDR_BASE) begin
			last_base <= wr_data[7:3];
		end
	end

	vector_follows_inta: assert property (@(posedge clock) disable iff (!rst_n)
		vector_valid == $past(inta))
		else $error("vector_valid is not inta delayed by one cycle");

	quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !int_out && !vector_valid)
		else $error("int_out or vector_valid high during reset");

	quiet_after_reset: assert property (@(posedge clock) $rose(rst_n) |=> !int_out && !vector_valid)
		else $error("int_out or vector_valid high right after reset");

	single_valid: assert property (@(posedge clock) disable iff (!rst_n)
		vector_valid |=> !vector_valid)
		else $error("vector_valid high two cycles running");

	base_in_vector: assert property (@(posedge clock) disable iff (!rst_n)
		vector_valid |-> vector[7:3] == last_base)
		else $error("Vector upper bits differ from the last written base");

endmodule

bind pic_top pic_assertions pic_assertions_i (
	.clock, .rst_n, .wr_en, .wr_addr, .wr_data, .inta, .int_out, .vector_valid, .vector
);

`default_nettype wire

// ==== bench/pic_tb.sv ====
`default_nettype none

`include "pic_consts.svh"

module pic_tb import pic_pkg::*; ();

	localparam int max_cycles = 4000;

	logic clock = 1'b0;
	logic rst_n = 1'b0;
	logic [7:0] ir = '0;
	logic wr_en = 1'b0;
	logic [1:0] wr_addr = '0;
	logic [7:0] wr_data = '0;
	logic inta = 1'b0;
	wire int_out;
	wire vector_valid;
	wire [7:0] vector;
	int seed;
	int cycles = 0;

	// Reference model
	logic [7:0] m_irr, m_isr, m_mask;
	logic [2:0] m_rot; // Lowest-priority line
	logic [4:0] m_base;
	logic m_aeoi, m_arot, m_sfnm, m_smm;

	pic_top pic_top_i (
		.clock, .rst_n, .ir, .wr_en, .wr_addr, .wr_data, .inta,
		.int_out, .vector_valid, .vector
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Model queries walked from the highest-priority line down

	function automatic int find_winner();
		int line;
		logic [7:0] live_isr;
		live_isr = m_smm ? (m_isr & ~m_mask) : m_isr;
		for (int i = 1; i <= 8; i++) begin
			line = (m_rot + i) % 8;
			if (live_isr[line] && !m_sfnm)
				return -1;
			if (m_irr[line] && !m_mask[line])
				return line;
			if (live_isr[line])
				return -1; // SFNM lets the same level through only
		end
		return -1;
	endfunction

	function automatic int top_in_service();
		int line;
		for (int i = 1; i <= 8; i++) begin
			line = (m_rot + i) % 8;
			if (m_isr[line])
				return line;
		end
		return -1;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host tasks start and end 2 units after an edge

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		wr_addr = addr;
		wr_data = data;
		wr_en = 1'b1;
		@(posedge clock);
		#2;
		wr_en = 1'b0;
		case (addr)
			`PIC_ADDR_MASK: m_mask = data;
			`PIC_ADDR_BASE: m_base = data[7:3];
			`PIC_ADDR_MODE: begin
				m_aeoi = data[`PIC_MODE_AEOI];
				m_arot = data[`PIC_MODE_AROT];
				m_sfnm = data[`PIC_MODE_SFNM];
				m_smm = data[`PIC_MODE_SMM];
			end
			default: if (data[`PIC_CMD_MSB:`PIC_CMD_LSB] == SET_PRIORITY) m_rot = data[2:0];
		endcase
	endtask

	task automatic pulse_ir(input logic [7:0] lines);
		ir = lines;
		@(posedge clock);
		#2;
		ir = '0;
		m_irr = m_irr | lines;
		@(posedge clock); // Low cycle so the next pulse is a fresh edge
		#2;
	endtask

	task automatic eoi(input pic_cmd_e cmd, input logic [2:0] level);
		int top;
		top = top_in_service();
		write_reg(`PIC_ADDR_CMD, {cmd, 2'b00, level});
		@(posedge clock);
		#2;
		case (cmd)
			NONSPEC_EOI: if (top >= 0) m_isr[top] = 1'b0;
			SPEC_EOI: m_isr[level] = 1'b0;
			ROT_NONSPEC_EOI: if (top >= 0) begin
				m_isr[top] = 1'b0;
				m_rot = 3'(top);
			end
			ROT_SPEC_EOI: begin
				m_isr[level] = 1'b0;
				m_rot = level;
			end
			default: ;
		endcase
	endtask

	task automatic acknowledge();
		int win;
		logic [7:0] want;
		win = find_winner();
		while (win >= 0 && !int_out) begin
			@(posedge clock);
			#2;
		end
		want = {m_base, (win >= 0) ? 3'(win) : 3'd7}; // Level 7 when spurious
		inta = 1'b1;
		@(posedge clock);
		#2;
		inta = 1'b0;
		assert (vector_valid && vector == want)
			else report_failure($sformatf("MISMATCH at time %0t: vector expected %h, got %h",
				$time, want, vector));
		if (win >= 0) begin
			m_irr[win] = 1'b0;
			if (!m_aeoi)
				m_isr[win] = 1'b1;
			else if (m_arot)
				m_rot = 3'(win);
		end
		@(posedge clock);
		#2;
	endtask

	task automatic check_int_out();
		logic want;
		@(posedge clock);
		#2;
		want = find_winner() >= 0;
		assert (int_out == want)
			else report_failure($sformatf("MISMATCH at time %0t: int_out expected %b, got %b",
				$time, want, int_out));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scenarios

	initial begin
		logic [31:0] pick;
		seed = 32'hcb20a931;
		m_irr = '0;
		m_isr = '0;
		m_mask = '1;
		m_rot = 3'd7;
		m_base = '0;
		{m_aeoi, m_arot, m_sfnm, m_smm} = '0;
		repeat (4) @(posedge clock);
		#2;
		rst_n = 1'b1;

		write_reg(`PIC_ADDR_BASE, 8'hA8);
		write_reg(`PIC_ADDR_MASK, 8'h00);
		pulse_ir(8'b0100_1010); // Fixed priority gives 1 then 3 then 6
		repeat (3) begin
			acknowledge();
			eoi(NONSPEC_EOI, 3'd0);
		end

		write_reg(`PIC_ADDR_MASK, 8'h10);
		pulse_ir(8'h10);
		check_int_out();
		write_reg(`PIC_ADDR_MASK, 8'h00);
		check_int_out();
		acknowledge();
		eoi(NONSPEC_EOI, 3'd0);

		// Nesting behind level 2
		pulse_ir(8'h04);
		acknowledge();
		pulse_ir(8'h20);
		check_int_out();
		pulse_ir(8'h02);
		acknowledge();
		eoi(NONSPEC_EOI, 3'd0);
		check_int_out();
		eoi(SPEC_EOI, 3'd2);
		acknowledge();
		eoi(NONSPEC_EOI, 3'd0);
		write_reg(`PIC_ADDR_MODE, 8'(1 << `PIC_MODE_SFNM));
		pulse_ir(8'h04);
		acknowledge();
		pulse_ir(8'h04);
		check_int_out();
		acknowledge();
		eoi(NONSPEC_EOI, 3'd0);
		write_reg(`PIC_ADDR_MODE, 8'h00);

		pulse_ir(8'h08);
		acknowledge();
		eoi(ROT_SPEC_EOI, 3'd3);
		pulse_ir(8'h14);
		repeat (2) begin
			acknowledge();
			eoi(NONSPEC_EOI, 3'd0);
		end
		eoi(SET_PRIORITY, 3'd5);
		pulse_ir(8'h41);
		repeat (2) begin
			acknowledge();
			eoi(NONSPEC_EOI, 3'd0);
		end
		eoi(SET_PRIORITY, 3'd7);

		write_reg(`PIC_ADDR_MODE, 8'(1 << `PIC_MODE_AEOI));
		pulse_ir(8'h2A);
		repeat (3) acknowledge();
		write_reg(`PIC_ADDR_MODE, 8'(1 << `PIC_MODE_AEOI) | 8'(1 << `PIC_MODE_AROT));
		pulse_ir(8'h44);
		repeat (2) acknowledge();
		eoi(SET_PRIORITY, 3'd7);
		write_reg(`PIC_ADDR_MODE, 8'(1 << `PIC_MODE_SMM));
		pulse_ir(8'h04);
		acknowledge();
		pulse_ir(8'h20);
		check_int_out();
		write_reg(`PIC_ADDR_MASK, 8'h04);
		check_int_out();
		acknowledge();
		eoi(SPEC_EOI, 3'd5);
		eoi(SPEC_EOI, 3'd2);
		write_reg(`PIC_ADDR_MASK, 8'h00);
		write_reg(`PIC_ADDR_MODE, 8'h00);

		for (int n = 0; n < 150; n++) begin
			pick = $random(seed);
			case (pick[1:0])
				2'd0: pulse_ir(pick[15:8]);
				2'd1: if (find_winner() >= 0) acknowledge();
				2'd2: eoi(NONSPEC_EOI, 3'd0);
				default: eoi(ROT_NONSPEC_EOI, 3'd0);
			endcase
		end
		while (m_irr != '0 || m_isr != '0) begin
			if (find_winner() >= 0)
				acknowledge();
			else
				eoi(NONSPEC_EOI, 3'd0);
		end
		check_int_out();
		acknowledge(); // Nothing pending

		check_int_out();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/pic_pkg.sv
source/pic_request_latch.sv
source/pic_priority_resolver.sv
source/pic_in_service.sv
source/pic_control.sv
source/pic_top.sv
bench/pic_assertions.sv
bench/pic_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pic_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vpic_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
